//--- design/core_settings.svh
// widths, register count and unit tags of the core
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath
`define WORD_W 32

// source tags, wide enough for the unit numbering
`define TAG_W 3

// architectural registers
`define REG_COUNT 32
`define REG_ID_W 5

// unit tags, lower tag wins the cdb
`define TAG_NONE 0 // no producer, value is ready
`define TAG_ADDER 1
`define TAG_LOGIC 2

`endif

//--- design/tomasulo_pkg.sv
// word, tag, operand, cdb and operation types plus the cdb capture rule
`include "core_settings.svh"

package tomasulo_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`TAG_W-1:0] tag_t;
    typedef logic [`REG_ID_W-1:0] reg_id_t;

    // raw operation field on the issue bus
    typedef logic [1:0] op_code_t;

    // tag is zero whenever ready is set
    typedef struct packed {
        logic  ready;
        tag_t  tag;
        word_t value;
    } operand_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t value;
    } cdb_t;

    typedef enum logic [1:0] {
        ADD_PASS = 2'd0, // result is a
        ADD_ADD  = 2'd1,
        ADD_SUB  = 2'd2,
        ADD_SLT  = 2'd3  // unsigned compare
    } adder_op_t;

    typedef enum logic [1:0] {
        LOGIC_OR  = 2'd0,
        LOGIC_AND = 2'd1,
        LOGIC_NOT = 2'd2, // b ignored
        LOGIC_XOR = 2'd3
    } logic_op_t;

    // a waiting operand picks up the broadcast that carries its tag
    function automatic operand_t capture(operand_t op, cdb_t bus);
        operand_t result;
        result = op;
        if (!op.ready && bus.valid && bus.tag == op.tag) begin
            result.ready = 1'b1;
            result.tag   = tag_t'(`TAG_NONE);
            result.value = bus.value;
        end
        return result;
    endfunction

endpackage

//--- design/issue_if.sv
// issue bus and station to unit dispatch interfaces
`timescale 1ns/1ps

// valid here already means the issue is accepted
interface issue_if;
    import tomasulo_pkg::*;

    logic     valid;
    op_code_t op;
    reg_id_t  dest;
    operand_t src_a;
    operand_t src_b;  // may be an immediate
    tag_t     tag;    // target unit

    modport receiver (
        input valid,
        input op,
        input dest,
        input src_a,
        input src_b,
        input tag
    );
endinterface

interface dispatch_if #(
    parameter type op_t = tomasulo_pkg::op_code_t
);
    import tomasulo_pkg::*;

    logic     full;   // station holds an instruction
    logic     ready;  // both operands captured
    op_t      op;
    operand_t a;
    operand_t b;
    logic     take;   // unit moves the instruction into its buffer

    modport station (output full, ready, op, a, b, input take);
    modport unit (input full, ready, op, a, b, output take);
endinterface

//--- design/tag_register_file.sv
// tagged register file with rename at issue, cdb snooping and three read ports
`timescale 1ns/1ps
`include "core_settings.svh"

module tag_register_file (
    input  logic                   clk,
    input  logic                   rst,
    issue_if.receiver              issue,
    input  tomasulo_pkg::cdb_t     cdb,
    input  tomasulo_pkg::reg_id_t  rd_a_id,
    input  tomasulo_pkg::reg_id_t  rd_b_id,
    output tomasulo_pkg::operand_t rd_a,
    output tomasulo_pkg::operand_t rd_b,
    input  tomasulo_pkg::reg_id_t  dbg_id,
    output tomasulo_pkg::operand_t dbg_data
);
    import tomasulo_pkg::*;

    localparam operand_t READY_ZERO = '{
        ready: 1'b1,
        tag:   tag_t'(`TAG_NONE),
        value: word_t'(0)
    };

    // register 0 has no storage
    operand_t regs [1:`REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= READY_ZERO;
            end
        end else begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                // rename beats a broadcast in the same cycle
                if (issue.valid && issue.dest == reg_id_t'(i)) begin
                    regs[i] <= '{ready: 1'b0, tag: issue.tag, value: word_t'(0)};
                end else begin
                    regs[i] <= capture(regs[i], cdb);
                end
            end
        end
    end

    function automatic operand_t read_reg(input reg_id_t id);
        if (id == reg_id_t'(0)) begin
            return READY_ZERO;
        end
        return regs[id];
    endfunction

    // no cdb bypass here, the stations capture same-cycle broadcasts
    always_comb begin
        rd_a     = read_reg(rd_a_id);
        rd_b     = read_reg(rd_b_id);
        dbg_data = read_reg(dbg_id);
    end

endmodule

//--- design/reservation_station.sv
// single-entry reservation station with issue-time capture and cdb snooping
`timescale 1ns/1ps
`include "core_settings.svh"

module reservation_station #(
    parameter type op_t = tomasulo_pkg::adder_op_t
) (
    input  logic               clk,
    input  logic               rst,
    issue_if.receiver          issue,
    input  tomasulo_pkg::cdb_t cdb,
    dispatch_if.station        disp
);
    import tomasulo_pkg::*;

    // tag follows from the payload this station serves
    localparam tag_t MY_TAG = (type(op_t) == type(adder_op_t)) ? tag_t'(`TAG_ADDER)
                                                                : tag_t'(`TAG_LOGIC);

    logic     full;
    logic     load;
    op_t      op;
    operand_t a;
    operand_t b;

    assign load = issue.valid && issue.tag == MY_TAG && !full;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (disp.take) begin
            full <= 1'b0; // buffer loads on this edge
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            op <= op_t'(issue.op);
            a  <= capture(issue.src_a, cdb); // broadcast during issue
            b  <= capture(issue.src_b, cdb);
        end else if (full) begin
            // operand b is awaited even for ops that ignore it
            a <= capture(a, cdb);
            b <= capture(b, cdb);
        end
    end

    assign disp.full  = full;
    assign disp.ready = a.ready && b.ready;
    assign disp.op    = op;
    assign disp.a     = a;
    assign disp.b     = b;

endmodule

//--- design/adder_unit.sv
// adder datapath and result buffer that requests the cdb
`timescale 1ns/1ps

module adder_unit (
    input  logic                clk,
    input  logic                rst,
    dispatch_if.unit            disp,
    input  logic                grant,
    output logic                request,
    output tomasulo_pkg::word_t result
);
    import tomasulo_pkg::*;

    word_t sum;

    always_comb begin
        case (disp.op)
            ADD_PASS: sum = disp.a.value;
            ADD_ADD:  sum = disp.a.value + disp.b.value;
            ADD_SUB:  sum = disp.a.value - disp.b.value;
            ADD_SLT:  sum = word_t'(disp.a.value < disp.b.value);
            default:  sum = disp.a.value;
        endcase
    end

    // only an empty buffer pulls from the station
    assign disp.take = !request && disp.full && disp.ready;

    // request doubles as the buffer full flag
    always_ff @(posedge clk) begin
        if (rst) begin
            request <= 1'b0;
        end else if (disp.take) begin
            request <= 1'b1;
        end else if (grant) begin
            request <= 1'b0; // value was on the cdb this cycle
        end
    end

    always_ff @(posedge clk) begin
        if (disp.take) begin
            result <= sum;
        end
    end

endmodule

//--- design/logic_unit.sv
// logic datapath and result buffer, second in line for the cdb
`timescale 1ns/1ps

module logic_unit (
    input  logic                clk,
    input  logic                rst,
    dispatch_if.unit            disp,
    input  logic                grant,
    output logic                request,
    output tomasulo_pkg::word_t result
);
    import tomasulo_pkg::*;

    word_t answer;

    always_comb begin
        case (disp.op)
            LOGIC_OR:  answer = disp.a.value | disp.b.value;
            LOGIC_AND: answer = disp.a.value & disp.b.value;
            LOGIC_NOT: answer = ~disp.a.value;
            LOGIC_XOR: answer = disp.a.value ^ disp.b.value;
            default:   answer = disp.a.value;
        endcase
    end

    assign disp.take = !request && disp.full && disp.ready;

    // grant may lag behind the adder for several cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            request <= 1'b0;
        end else if (disp.take) begin
            request <= 1'b1;
        end else if (grant) begin
            request <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (disp.take) begin
            result <= answer;
        end
    end

endmodule

//--- design/cdb_arbiter.sv
// fixed-priority cdb grant and broadcast multiplexer
`timescale 1ns/1ps
`include "core_settings.svh"

module cdb_arbiter (
    input  logic                adder_request,
    input  logic                logic_request,
    input  tomasulo_pkg::word_t adder_result,
    input  tomasulo_pkg::word_t logic_result,
    output logic                adder_grant,
    output logic                logic_grant,
    output tomasulo_pkg::cdb_t  cdb
);
    import tomasulo_pkg::*;

    // lower tag first
    assign adder_grant = adder_request;
    assign logic_grant = logic_request && !adder_request;

    always_comb begin
        cdb.valid = adder_grant || logic_grant;
        if (adder_grant) begin
            cdb.tag   = tag_t'(`TAG_ADDER);
            cdb.value = adder_result;
        end else if (logic_grant) begin
            cdb.tag   = tag_t'(`TAG_LOGIC);
            cdb.value = logic_result;
        end else begin
            cdb.tag   = tag_t'(`TAG_NONE); // idle bus
            cdb.value = word_t'(0);
        end
    end

endmodule

//--- design/tomasulo_core.sv
// out-of-order core top with register file, two stations, two units and the cdb arbiter
`timescale 1ns/1ps
`include "core_settings.svh"

module tomasulo_core (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue_valid,
    input  tomasulo_pkg::tag_t       issue_unit,
    input  tomasulo_pkg::op_code_t   issue_op,
    input  tomasulo_pkg::reg_id_t    issue_dest,
    input  tomasulo_pkg::reg_id_t    issue_src_a,
    input  logic                     issue_src_b_is_imm,
    input  tomasulo_pkg::reg_id_t    issue_src_b,
    input  tomasulo_pkg::word_t      issue_imm,
    output logic                     issue_ready,
    output logic                     cdb_valid,
    output tomasulo_pkg::tag_t       cdb_tag,
    output tomasulo_pkg::word_t      cdb_value,
    input  tomasulo_pkg::reg_id_t    dbg_id,
    output logic                     dbg_ready,
    output tomasulo_pkg::word_t      dbg_value
);
    import tomasulo_pkg::*;

    issue_if                         issue_bus ();
    dispatch_if #(.op_t(adder_op_t)) adder_disp ();
    dispatch_if #(.op_t(logic_op_t)) logic_disp ();

    cdb_t     cdb;
    operand_t rd_a;
    operand_t rd_b;
    operand_t dbg_data;
    logic     adder_request;
    logic     logic_request;
    logic     adder_grant;
    logic     logic_grant;
    word_t    adder_result;
    word_t    logic_result;
    logic     adder_idle;
    logic     logic_idle;
    logic     unit_known;

    // station and result buffer both empty
    assign adder_idle = !adder_disp.full && !adder_request;
    assign logic_idle = !logic_disp.full && !logic_request;

    always_comb begin
        unit_known = 1'b1;
        case (issue_unit)
            tag_t'(`TAG_ADDER): issue_ready = adder_idle;
            tag_t'(`TAG_LOGIC): issue_ready = logic_idle;
            default: begin
                issue_ready = 1'b1; // consumed as a no-op
                unit_known  = 1'b0;
            end
        endcase
    end

    assign issue_bus.valid = issue_valid && issue_ready && unit_known;
    assign issue_bus.op    = issue_op;
    assign issue_bus.dest  = issue_dest;
    assign issue_bus.tag   = issue_unit;
    assign issue_bus.src_a = rd_a;
    assign issue_bus.src_b = issue_src_b_is_imm
                           ? operand_t'{ready: 1'b1, tag: tag_t'(`TAG_NONE), value: issue_imm}
                           : rd_b;

    tag_register_file tag_register_file_i (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue_bus),
        .cdb      (cdb),
        .rd_a_id  (issue_src_a),
        .rd_b_id  (issue_src_b),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .dbg_id   (dbg_id),
        .dbg_data (dbg_data)
    );

    reservation_station #(.op_t(adder_op_t)) adder_station_i (
        .clk   (clk),
        .rst   (rst),
        .issue (issue_bus),
        .cdb   (cdb),
        .disp  (adder_disp)
    );

    reservation_station #(.op_t(logic_op_t)) logic_station_i (
        .clk   (clk),
        .rst   (rst),
        .issue (issue_bus),
        .cdb   (cdb),
        .disp  (logic_disp)
    );

    adder_unit adder_unit_i (
        .clk     (clk),
        .rst     (rst),
        .disp    (adder_disp),
        .grant   (adder_grant),
        .request (adder_request),
        .result  (adder_result)
    );

    logic_unit logic_unit_i (
        .clk     (clk),
        .rst     (rst),
        .disp    (logic_disp),
        .grant   (logic_grant),
        .request (logic_request),
        .result  (logic_result)
    );

    cdb_arbiter cdb_arbiter_i (
        .adder_request (adder_request),
        .logic_request (logic_request),
        .adder_result  (adder_result),
        .logic_result  (logic_result),
        .adder_grant   (adder_grant),
        .logic_grant   (logic_grant),
        .cdb           (cdb)
    );

    assign cdb_valid = cdb.valid;
    assign cdb_tag   = cdb.tag;
    assign cdb_value = cdb.value;
    assign dbg_ready = dbg_data.ready;
    assign dbg_value = dbg_data.value;

endmodule

//--- testbench/core_ref.svh
// reference model, shadow registers, expected cdb values per unit and typed compare tasks
`ifndef CORE_REF_SVH
`define CORE_REF_SVH

// architectural state in program order
word_t shadow [`REG_COUNT] = '{default: '0};

// results still owed by each unit, oldest first
word_t adder_q [$];
word_t logic_q [$];

int check_count = 0;
int error_count = 0;

// result of one operation, op codes as carried on the issue bus
function automatic word_t ref_result(input tag_t unit, input op_code_t op,
                                     input word_t a, input word_t b);
    word_t r;
    r = a;
    if (unit == tag_t'(`TAG_ADDER)) begin
        case (op)
            2'd0: r = a; // pass
            2'd1: r = a + b;
            2'd2: r = a - b;
            2'd3: r = (a < b) ? word_t'(1) : word_t'(0); // unsigned compare
        endcase
    end else begin
        case (op)
            2'd0: r = a | b;
            2'd1: r = a & b;
            2'd2: r = ~a; // b does not matter
            2'd3: r = a ^ b;
        endcase
    end
    return r;
endfunction

task automatic check_word(input string name, input word_t got, input word_t expected);
    check_count++;
    if (got !== expected) begin
        error_count++;
        $display("[ERROR] %0d ns %s: got %h, expected %h", $time, name, got, expected);
    end
endtask

task automatic check_tag(input string name, input tag_t got, input tag_t expected);
    check_count++;
    if (got !== expected) begin
        error_count++;
        $display("[ERROR] %0d ns %s: got %0d, expected %0d", $time, name, got, expected);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic expected);
    check_count++;
    if (got !== expected) begin
        error_count++;
        $display("[ERROR] %0d ns %s: got %b, expected %b", $time, name, got, expected);
    end
endtask

`endif

//--- testbench/tomasulo_core_tb.sv
// testbench for the core: clock, reset, stimulus, cdb monitor, timeout and report
`timescale 1ns/1ps
`include "core_settings.svh"

module tomasulo_core_tb;
    import tomasulo_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int IMM_LOADS   = `REG_COUNT - 1;
    localparam int CHAIN_LEN   = 64;
    localparam int PAIRS       = 4;
    localparam int HELD_ISSUES = 4;
    localparam int ISSUE_TOTAL = IMM_LOADS + CHAIN_LEN + 2 * PAIRS + HELD_ISSUES;
    localparam int CYCLE_LIMIT = 40 * ISSUE_TOTAL + 100;
    localparam tag_t UNIT_ADDER = tag_t'(`TAG_ADDER);
    localparam tag_t UNIT_LOGIC = tag_t'(`TAG_LOGIC);

    logic     clk = 1'b0;
    logic     rst;
    logic     issue_valid;
    tag_t     issue_unit;
    op_code_t issue_op;
    reg_id_t  issue_dest;
    reg_id_t  issue_src_a;
    logic     issue_src_b_is_imm;
    reg_id_t  issue_src_b;
    word_t    issue_imm;
    logic     issue_ready;
    logic     cdb_valid;
    tag_t     cdb_tag;
    word_t    cdb_value;
    reg_id_t  dbg_id;
    logic     dbg_ready;
    word_t    dbg_value;

    integer seed = 32'hf5272502;
    int     cycle_count = 0;
    int     errors_before = 0;
    tag_t   seen_tags [$]; // tags in broadcast order

    `include "core_ref.svh"

    tomasulo_core tomasulo_core_i (
        .clk                (clk),
        .rst                (rst),
        .issue_valid        (issue_valid),
        .issue_unit         (issue_unit),
        .issue_op           (issue_op),
        .issue_dest         (issue_dest),
        .issue_src_a        (issue_src_a),
        .issue_src_b_is_imm (issue_src_b_is_imm),
        .issue_src_b        (issue_src_b),
        .issue_imm          (issue_imm),
        .issue_ready        (issue_ready),
        .cdb_valid          (cdb_valid),
        .cdb_tag            (cdb_tag),
        .cdb_value          (cdb_value),
        .dbg_id             (dbg_id),
        .dbg_ready          (dbg_ready),
        .dbg_value          (dbg_value)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the core stopped making progress", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    // each broadcast settles the oldest result owed by its unit
    always @(negedge clk) begin : cdb_monitor
        word_t expect_val;
        if (!rst && cdb_valid) begin
            seen_tags.push_back(cdb_tag);
            if (cdb_tag == UNIT_ADDER && adder_q.size() > 0) begin
                expect_val = adder_q.pop_front();
                check_word("cdb_value (adder)", cdb_value, expect_val);
            end else if (cdb_tag == UNIT_LOGIC && logic_q.size() > 0) begin
                expect_val = logic_q.pop_front();
                check_word("cdb_value (logic)", cdb_value, expect_val);
            end else begin
                error_count++;
                $display("%0d ns: broadcast with tag %0d and value %h that no issue produced",
                         $time, cdb_tag, cdb_value);
            end
        end
    end

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    task automatic note_failure(input string what);
        error_count++;
        $display("%0d ns: %s", $time, what);
    endtask

    task automatic report_test(input int number, input string name);
        if (error_count == errors_before) begin
            $display("test %0d %s: passed", number, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", number, name,
                     error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    // starts on a rising edge, returns on the edge that accepts the issue
    task automatic issue_instr(input tag_t unit, input op_code_t op, input reg_id_t dest,
                               input reg_id_t src_a, input logic b_is_imm,
                               input reg_id_t src_b, input word_t imm, output int stalls);
        word_t a_val;
        word_t b_val;
        word_t expect_val;
        stalls = 0;
        issue_valid        <= 1'b1;
        issue_unit         <= unit;
        issue_op           <= op;
        issue_dest         <= dest;
        issue_src_a        <= src_a;
        issue_src_b_is_imm <= b_is_imm;
        issue_src_b        <= src_b;
        issue_imm          <= imm;
        @(negedge clk);
        while (!issue_ready) begin
            stalls++;
            @(negedge clk);
        end
        // accepted on the coming edge
        a_val      = shadow[src_a];
        b_val      = b_is_imm ? imm : shadow[src_b];
        expect_val = ref_result(unit, op, a_val, b_val);
        if (unit == UNIT_ADDER) begin
            adder_q.push_back(expect_val);
        end else begin
            logic_q.push_back(expect_val);
        end
        shadow[dest] = expect_val;
        @(posedge clk);
    endtask

    task automatic wait_drain();
        issue_valid <= 1'b0;
        @(negedge clk);
        while (adder_q.size() != 0 || logic_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic check_broadcast_count(input int expected);
        if (seen_tags.size() != expected) begin
            error_count++;
            $display("[ERROR] %0d ns broadcast count: got %0d, expected %0d",
                     $time, seen_tags.size(), expected);
        end
    endtask

    task automatic check_all_registers();
        for (int i = 0; i < `REG_COUNT; i++) begin
            @(posedge clk);
            dbg_id <= reg_id_t'(i);
            @(negedge clk);
            check_flag($sformatf("dbg_ready r%0d", i), dbg_ready, 1'b1);
            check_word($sformatf("dbg_value r%0d", i), dbg_value, shadow[i]);
        end
        @(posedge clk);
    endtask

    task automatic run_reset_test();
        @(negedge clk);
        check_flag("cdb_valid", cdb_valid, 1'b0);
        check_flag("issue_ready (adder)", issue_ready, 1'b1);
        @(posedge clk);
        issue_unit <= UNIT_LOGIC;
        @(negedge clk);
        check_flag("issue_ready (logic)", issue_ready, 1'b1);
        check_all_registers();
    endtask

    // r0 plus an immediate into every register
    task automatic run_immediate_test();
        int stalls;
        seen_tags.delete();
        for (int i = 1; i < `REG_COUNT; i++) begin
            issue_instr(UNIT_ADDER, 2'd1, reg_id_t'(i), 5'd0, 1'b1, 5'd0,
                        word_t'(next_random()), stalls);
        end
        wait_drain();
        check_broadcast_count(IMM_LOADS);
        foreach (seen_tags[i]) begin
            check_tag("cdb_tag", seen_tags[i], UNIT_ADDER);
        end
        check_all_registers();
    endtask

    // r0..r7 only, so most operands wait on a producer
    task automatic run_chain_test();
        int   stalls;
        int   gap;
        tag_t unit;
        for (int n = 0; n < CHAIN_LEN; n++) begin
            unit = ((next_random() % 2) != 0) ? UNIT_LOGIC : UNIT_ADDER;
            issue_instr(unit, op_code_t'(next_random()), reg_id_t'(1 + next_random() % 7),
                        reg_id_t'(next_random() % 8), (next_random() % 4) == 0,
                        reg_id_t'(next_random() % 8), word_t'(next_random()), stalls);
            gap = int'(next_random() % 3); // idle cycles give same-cycle capture
            if (gap != 0) begin
                issue_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
        end
        wait_drain();
    endtask

    // adder then logic back to back, ready operands
    task automatic run_pair_test();
        int stalls;
        for (int p = 0; p < PAIRS; p++) begin
            seen_tags.delete();
            issue_instr(UNIT_ADDER, op_code_t'(next_random()), reg_id_t'(24 + p),
                        reg_id_t'(1 + next_random() % 23), 1'b0,
                        reg_id_t'(1 + next_random() % 23), word_t'(0), stalls);
            issue_instr(UNIT_LOGIC, op_code_t'(next_random()), reg_id_t'(28 + p),
                        reg_id_t'(1 + next_random() % 23), 1'b0,
                        reg_id_t'(1 + next_random() % 23), word_t'(0), stalls);
            wait_drain();
            check_broadcast_count(2);
            if (seen_tags.size() == 2) begin
                check_tag("cdb_tag first", seen_tags[0], UNIT_ADDER);
                check_tag("cdb_tag second", seen_tags[1], UNIT_LOGIC);
            end
        end
    endtask

    task automatic run_backpressure_test();
        int stalls;
        seen_tags.delete();
        issue_instr(UNIT_ADDER, 2'd1, 5'd20, 5'd1, 1'b1, 5'd0, word_t'(next_random()), stalls);
        issue_instr(UNIT_ADDER, 2'd2, 5'd21, 5'd20, 1'b0, 5'd2, word_t'(0), stalls);
        if (stalls == 0) begin
            note_failure("second adder issue was accepted while the adder was busy");
        end
        issue_instr(UNIT_LOGIC, 2'd3, 5'd22, 5'd21, 1'b0, 5'd3, word_t'(0), stalls);
        issue_instr(UNIT_LOGIC, 2'd0, 5'd23, 5'd22, 1'b0, 5'd21, word_t'(0), stalls);
        if (stalls == 0) begin
            note_failure("second logic issue was accepted while its station still waited");
        end
        wait_drain();
        check_broadcast_count(HELD_ISSUES);
    endtask

    initial begin
        rst                = 1'b1;
        issue_valid        = 1'b0;
        issue_unit         = UNIT_ADDER;
        issue_op           = '0;
        issue_dest         = '0;
        issue_src_a        = '0;
        issue_src_b_is_imm = 1'b0;
        issue_src_b        = '0;
        issue_imm          = '0;
        dbg_id             = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        run_reset_test();
        report_test(1, "reset state");
        run_immediate_test();
        report_test(2, "immediate loads");
        run_chain_test();
        report_test(3, "dependent chain");
        run_pair_test();
        report_test(4, "adder and logic pairs");
        run_backpressure_test();
        report_test(5, "back-pressure");
        check_all_registers();
        report_test(6, "final registers");

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+design
+incdir+testbench
design/tomasulo_pkg.sv
design/issue_if.sv
design/tag_register_file.sv
design/reservation_station.sv
design/adder_unit.sv
design/logic_unit.sv
design/cdb_arbiter.sv
design/tomasulo_core.sv
testbench/tomasulo_core_tb.sv

//--- Makefile
# Verilator simulation of the tomasulo core, every variable can be overridden

VERILATOR ?= verilator
TOP       ?= tomasulo_core_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "Test OK" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
